// File: Makefile
# Verilator build and run of the bus fabric testbench
SIM  := obj_dir/Vtb_nebula
SRCS := $(wildcard design/*.sv tests/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) src.f
	verilator --binary --timing --assert --top-module tb_nebula -f src.f \
		--Mdir obj_dir -o Vtb_nebula

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	@cat sim.log
	@grep -qx "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

// File: design/nebula_top.sv
//*********************************************************************
// Shared bus fabric top
//*********************************************************************
`timescale 1ns/1ps

module nebula_top (
    input  logic                                                wb_clk_i,
    input  logic                                                reset_i,
    input  wb_pkg::wb_req_t                                     host_req_i,
    output wb_pkg::wb_rsp_t                                     host_rsp_o,
    input  wb_pkg::wb_req_t [pad_pkg::NUM_TEAMS-1:0]            team_req_i,
    output wb_pkg::wb_rsp_t [pad_pkg::NUM_TEAMS-1:0]            team_rsp_o,
    input  pad_pkg::pad_out_t [pad_pkg::NUM_TEAMS-1:0]          team_pad_i,
    input  logic [pad_pkg::NUM_TEAMS-1:0][pad_pkg::LA_W-1:0]    team_la_i,
    output logic [pad_pkg::GPIO_W-1:0]                          io_out_o,
    output logic [pad_pkg::GPIO_W-1:0]                          io_oeb_o,
    output logic [pad_pkg::LA_W-1:0]                            la_data_out_o
);
    import wb_pkg::*;

    wb_req_t [NUM_MANAGERS-1:0] mgr_req;
    wb_rsp_t [NUM_MANAGERS-1:0] mgr_rsp;
    wb_req_t                    bus_req;
    wb_rsp_t                    bus_rsp;
    wb_req_t                    sram_req;
    wb_req_t                    pad_req;
    wb_rsp_t                    sram_rsp;
    wb_rsp_t                    pad_rsp;

    assign mgr_req    = {team_req_i, host_req_i};   // Host is manager 0
    assign host_rsp_o = mgr_rsp[0];
    assign team_rsp_o = mgr_rsp[NUM_MANAGERS-1:1];

    wb_arbiter u_arbiter (
        .wb_clk_i  (wb_clk_i),
        .reset_i   (reset_i),
        .mgr_req_i (mgr_req),
        .mgr_rsp_o (mgr_rsp),
        .bus_req_o (bus_req),
        .bus_rsp_i (bus_rsp)
    );

    wb_decoder u_decoder (
        .wb_clk_i   (wb_clk_i),
        .reset_i    (reset_i),
        .bus_req_i  (bus_req),
        .bus_rsp_o  (bus_rsp),
        .sram_req_o (sram_req),
        .pad_req_o  (pad_req),
        .sram_rsp_i (sram_rsp),
        .pad_rsp_i  (pad_rsp)
    );

    wb_sram u_sram (
        .wb_clk_i (wb_clk_i),
        .reset_i  (reset_i),
        .req_i    (sram_req),
        .rsp_o    (sram_rsp)
    );

    pad_select u_pad_select (
        .wb_clk_i      (wb_clk_i),
        .reset_i       (reset_i),
        .req_i         (pad_req),
        .rsp_o         (pad_rsp),
        .team_pad_i    (team_pad_i),
        .team_la_i     (team_la_i),
        .io_out_o      (io_out_o),
        .io_oeb_o      (io_oeb_o),
        .la_data_out_o (la_data_out_o)
    );

endmodule

// File: design/pad_pkg.sv
//*********************************************************************
// Pad and team definitions
//*********************************************************************
package pad_pkg;

    localparam int NUM_TEAMS = 3;
    localparam int GPIO_W    = 38;
    localparam int LA_W      = 128;

    typedef logic [1:0] team_sel_t;

    // No team on the pins
    localparam team_sel_t TEAM_NONE = 2'd3;

    typedef struct packed {
        logic [GPIO_W-1:0] gpio_out;
        logic [GPIO_W-1:0] gpio_oeb;   // Active low enable
    } pad_out_t;

endpackage

// File: design/pad_select.sv
//*********************************************************************
// GPIO and LA source select
//*********************************************************************
`timescale 1ns/1ps

module pad_select (
    input  logic                                                wb_clk_i,
    input  logic                                                reset_i,
    input  wb_pkg::wb_req_t                                     req_i,
    output wb_pkg::wb_rsp_t                                     rsp_o,
    input  pad_pkg::pad_out_t [pad_pkg::NUM_TEAMS-1:0]          team_pad_i,
    input  logic [pad_pkg::NUM_TEAMS-1:0][pad_pkg::LA_W-1:0]    team_la_i,
    output logic [pad_pkg::GPIO_W-1:0]                          io_out_o,
    output logic [pad_pkg::GPIO_W-1:0]                          io_oeb_o,
    output logic [pad_pkg::LA_W-1:0]                            la_data_out_o
);
    import wb_pkg::*;
    import pad_pkg::*;

    team_sel_t         gpio_sel;
    team_sel_t         la_sel;
    logic              access;
    logic              hit_gpio;
    logic              hit_la;
    logic              ack_q;
    logic [DATA_W-1:0] rd_q;

    assign access   = req_i.cyc && req_i.stb && !ack_q;
    assign hit_gpio = (req_i.adr[ADDR_W-9:0] == PAD_GPIO_OFS);
    assign hit_la   = (req_i.adr[ADDR_W-9:0] == PAD_LA_OFS);

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ack_q    <= 1'b0;
            gpio_sel <= TEAM_NONE;
            la_sel   <= TEAM_NONE;
        end else begin
            ack_q <= access;
            if (access && req_i.we) begin
                if (hit_gpio) gpio_sel <= req_i.dat[1:0];
                if (hit_la)   la_sel   <= req_i.dat[1:0];
            end
        end
    end

    // Read back, other offsets give 0
    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            if (hit_gpio)    rd_q <= DATA_W'(gpio_sel);
            else if (hit_la) rd_q <= DATA_W'(la_sel);
            else             rd_q <= '0;
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rd_q;

    // Pin muxes
    always_comb begin
        if (gpio_sel == TEAM_NONE) begin
            io_out_o = '0;
            io_oeb_o = '1;   // All pins as inputs
        end else begin
            io_out_o = team_pad_i[gpio_sel].gpio_out;
            io_oeb_o = team_pad_i[gpio_sel].gpio_oeb;
        end
        la_data_out_o = (la_sel == TEAM_NONE) ? '0 : team_la_i[la_sel];
    end

    // Ack lands while the same request still strobes
    a_ack_after_stb: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        ack_q |-> req_i.cyc && req_i.stb && $stable(req_i.adr));

endmodule

// File: design/wb_arbiter.sv
//*********************************************************************
// Round-robin bus arbiter
//*********************************************************************
`timescale 1ns/1ps

module wb_arbiter (
    input  logic                                        wb_clk_i,
    input  logic                                        reset_i,
    input  wb_pkg::wb_req_t [wb_pkg::NUM_MANAGERS-1:0]  mgr_req_i,
    output wb_pkg::wb_rsp_t [wb_pkg::NUM_MANAGERS-1:0]  mgr_rsp_o,
    output wb_pkg::wb_req_t                             bus_req_o,
    input  wb_pkg::wb_rsp_t                             bus_rsp_i
);
    import wb_pkg::*;

    arb_state_e       state;
    logic [MGR_W-1:0] grant_idx;
    logic [MGR_W-1:0] last_idx;   // Search starts after this one
    logic [MGR_W-1:0] next_idx;
    logic             found;

    // Round-robin search over managers with cyc high
    always_comb begin : search
        int cand;
        found    = 1'b0;
        next_idx = last_idx;
        for (int k = 1; k <= NUM_MANAGERS; k++) begin
            cand = (int'(last_idx) + k) % NUM_MANAGERS;
            if (!found && mgr_req_i[cand].cyc) begin
                found    = 1'b1;
                next_idx = MGR_W'(cand);
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            state     <= ARB_IDLE;
            grant_idx <= '0;
            last_idx  <= MGR_W'(NUM_MANAGERS - 1);   // Host goes first
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (found) begin
                        grant_idx <= next_idx;
                        state     <= ARB_BUSY;
                    end
                end
                ARB_BUSY: begin
                    if (!mgr_req_i[grant_idx].cyc) begin   // Cycle finished
                        last_idx <= grant_idx;
                        state    <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    assign bus_req_o = (state == ARB_BUSY) ? mgr_req_i[grant_idx] : '0;

    // Response goes back to the granted manager only
    always_comb begin
        for (int m = 0; m < NUM_MANAGERS; m++) begin
            mgr_rsp_o[m] = '0;
            if (state == ARB_BUSY && grant_idx == MGR_W'(m)) begin
                mgr_rsp_o[m] = bus_rsp_i;
            end
        end
    end

    // A target ack must land while the granted manager still strobes
    a_ack_to_grant: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        bus_rsp_i.ack |-> (state == ARB_BUSY && mgr_req_i[grant_idx].stb));

endmodule

// File: design/wb_decoder.sv
//*********************************************************************
// Bus address decoder
//*********************************************************************
`timescale 1ns/1ps

module wb_decoder (
    input  logic            wb_clk_i,
    input  logic            reset_i,
    input  wb_pkg::wb_req_t bus_req_i,
    output wb_pkg::wb_rsp_t bus_rsp_o,
    output wb_pkg::wb_req_t sram_req_o,
    output wb_pkg::wb_req_t pad_req_o,
    input  wb_pkg::wb_rsp_t sram_rsp_i,
    input  wb_pkg::wb_rsp_t pad_rsp_i
);
    import wb_pkg::*;

    periph_e periph;
    logic    none_stb;
    logic    none_ack;

    always_comb begin
        case (bus_req_i.adr[ADDR_W-1 -: 8])
            REGION_SRAM: periph = PERIPH_SRAM;
            REGION_PAD:  periph = PERIPH_PAD;
            default:     periph = PERIPH_NONE;
        endcase
    end

    // Only the addressed target sees the strobes
    always_comb begin
        sram_req_o     = bus_req_i;
        sram_req_o.cyc = bus_req_i.cyc && (periph == PERIPH_SRAM);
        sram_req_o.stb = bus_req_i.stb && (periph == PERIPH_SRAM);
        pad_req_o      = bus_req_i;
        pad_req_o.cyc  = bus_req_i.cyc && (periph == PERIPH_PAD);
        pad_req_o.stb  = bus_req_i.stb && (periph == PERIPH_PAD);
    end

    assign none_stb = bus_req_i.cyc && bus_req_i.stb && (periph == PERIPH_NONE);

    // Unmapped responder, data 0 and writes dropped
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            none_ack <= 1'b0;
        end else begin
            none_ack <= none_stb && !none_ack;
        end
    end

    always_comb begin
        case (periph)
            PERIPH_SRAM: bus_rsp_o = sram_rsp_i;
            PERIPH_PAD:  bus_rsp_o = pad_rsp_i;
            default:     bus_rsp_o = '{ack: none_ack, dat: '0};
        endcase
    end

    // Targets never answer together
    a_one_ack: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        $onehot0({sram_rsp_i.ack, pad_rsp_i.ack, none_ack}));

endmodule

// File: design/wb_pkg.sv
//*********************************************************************
// Shared bus definitions
//*********************************************************************
package wb_pkg;

    localparam int ADDR_W       = 32;
    localparam int DATA_W       = 32;
    localparam int SEL_W        = 4;
    localparam int NUM_MANAGERS = 4;                     // Host plus three teams
    localparam int MGR_W        = $clog2(NUM_MANAGERS);

    // Address map, top address byte
    localparam logic [7:0] REGION_SRAM = 8'h30;
    localparam logic [7:0] REGION_PAD  = 8'h31;

    localparam int SRAM_WORDS = 256;
    localparam int SRAM_IDX_W = $clog2(SRAM_WORDS);      // Word index from adr[9:2]

    // Byte offsets inside the pad region
    localparam logic [ADDR_W-9:0] PAD_GPIO_OFS = 'h0;
    localparam logic [ADDR_W-9:0] PAD_LA_OFS   = 'h4;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [SEL_W-1:0]  sel;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] dat;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        PERIPH_SRAM,
        PERIPH_PAD,
        PERIPH_NONE
    } periph_e;

    typedef enum logic {
        ARB_IDLE,
        ARB_BUSY
    } arb_state_e;

endpackage

// File: design/wb_sram.sv
//*********************************************************************
// Bus SRAM with byte lanes
//*********************************************************************
`timescale 1ns/1ps

module wb_sram (
    input  logic            wb_clk_i,
    input  logic            reset_i,
    input  wb_pkg::wb_req_t req_i,
    output wb_pkg::wb_rsp_t rsp_o
);
    import wb_pkg::*;

    logic [DATA_W-1:0]     mem [SRAM_WORDS];
    logic [SRAM_IDX_W-1:0] idx;
    logic                  access;
    logic                  ack_q;
    logic [DATA_W-1:0]     rd_q;

    assign idx    = req_i.adr[SRAM_IDX_W+1:2];   // Word address
    assign access = req_i.cyc && req_i.stb && !ack_q;

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;   // One ack per request
        end
    end

    // Storage and read data
    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            if (req_i.we) begin
                for (int b = 0; b < SEL_W; b++) begin
                    if (req_i.sel[b]) begin
                        mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
                    end
                end
            end
            rd_q <= mem[idx];
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rd_q;

endmodule

// File: src.f
design/wb_pkg.sv
design/pad_pkg.sv
design/wb_arbiter.sv
design/wb_decoder.sv
design/wb_sram.sv
design/pad_select.sv
design/nebula_top.sv
tests/tb_nebula.sv

// File: tests/tb_nebula.sv
//*********************************************************************
// Bus fabric testbench
//*********************************************************************
`timescale 1ns/1ps

module tb_nebula;
    import wb_pkg::*;
    import pad_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 4;
    // Roughly 60 bus cycles of under 10 clocks each, plus resets and margin
    localparam int WATCHDOG_CYCLES = 2000;

    localparam logic [MGR_W-1:0]  HOST      = '0;
    localparam logic [ADDR_W-1:0] GPIO_ADR  = {REGION_PAD, PAD_GPIO_OFS};
    localparam logic [ADDR_W-1:0] LA_ADR    = {REGION_PAD, PAD_LA_OFS};
    localparam logic [ADDR_W-1:0] NONE_ADR  = 32'h4000_0010;   // Top byte unmapped
    localparam pad_out_t          IDLE_PINS = '{gpio_out: '0, gpio_oeb: '1};

    logic                            clk = 1'b0;
    logic                            reset;
    wb_req_t [NUM_MANAGERS-1:0]      mgr_req;    // Host at index 0
    wire wb_rsp_t [NUM_MANAGERS-1:0] mgr_rsp;
    pad_out_t [NUM_TEAMS-1:0]        team_pad;
    logic [NUM_TEAMS-1:0][LA_W-1:0]  team_la;
    logic [GPIO_W-1:0]               io_out;
    logic [GPIO_W-1:0]               io_oeb;
    logic [LA_W-1:0]                 la_out;
    integer                          seed;

    nebula_top dut (
        .wb_clk_i      (clk),
        .reset_i       (reset),
        .host_req_i    (mgr_req[0]),
        .host_rsp_o    (mgr_rsp[0]),
        .team_req_i    (mgr_req[NUM_MANAGERS-1:1]),
        .team_rsp_o    (mgr_rsp[NUM_MANAGERS-1:1]),
        .team_pad_i    (team_pad),
        .team_la_i     (team_la),
        .io_out_o      (io_out),
        .io_oeb_o      (io_oeb),
        .la_data_out_o (la_out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [MGR_W-1:0] team_mgr(input int t);
        return MGR_W'(t + 1);   // Teams follow the host
    endfunction

    function automatic logic [ADDR_W-1:0] sram_adr(input logic [7:0] w);
        return {REGION_SRAM, 14'h0, w, 2'b00};
    endfunction

    // Old word with the selected byte lanes replaced
    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
            input logic [DATA_W-1:0] new_w, input logic [SEL_W-1:0] lanes);
        logic [DATA_W-1:0] res;
        res = old_w;
        for (int b = 0; b < SEL_W; b++) begin
            if (lanes[b]) res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    function automatic pad_out_t pins_now();
        return '{gpio_out: io_out, gpio_oeb: io_oeb};
    endfunction

    task automatic stop_on_error();
        $display("Test FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_pad(input pad_out_t got, input pad_out_t exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s out 0x%h oeb 0x%h, expected out 0x%h oeb 0x%h", $time,
                     what, got.gpio_out, got.gpio_oeb, exp.gpio_out, exp.gpio_oeb);
            stop_on_error();
        end
    endtask

    task automatic check_la(input logic [LA_W-1:0] got, input logic [LA_W-1:0] exp,
                            input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s is 0x%h, expected 0x%h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    // One classic cycle, request held until ack then dropped
    task automatic bus_cycle(input logic [MGR_W-1:0] mgr, input logic wr,
                             input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                             input logic [SEL_W-1:0] lanes, output logic [DATA_W-1:0] rdata);
        @(posedge clk);
        mgr_req[mgr] <= '{cyc: 1'b1, stb: 1'b1, we: wr, sel: lanes, adr: addr, dat: wdata};
        @(posedge clk);
        while (!mgr_rsp[mgr].ack) @(posedge clk);
        rdata = mgr_rsp[mgr].dat;   // Valid with ack
        mgr_req[mgr] <= '0;
    endtask

    task automatic wb_write(input logic [MGR_W-1:0] mgr, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata, input logic [SEL_W-1:0] lanes);
        logic [DATA_W-1:0] unused;
        bus_cycle(mgr, 1'b1, addr, wdata, lanes, unused);
    endtask

    task automatic wb_read(input logic [MGR_W-1:0] mgr, input logic [ADDR_W-1:0] addr,
                           output logic [DATA_W-1:0] rdata);
        bus_cycle(mgr, 1'b0, addr, '0, '1, rdata);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic load_team_inputs();
        logic [95:0]                    raw;
        pad_out_t [NUM_TEAMS-1:0]       pads;
        logic [NUM_TEAMS-1:0][LA_W-1:0] las;
        for (int t = 0; t < NUM_TEAMS; t++) begin
            raw     = {$random(seed), $random(seed), $random(seed)};
            pads[t] = raw[$bits(pad_out_t)-1:0];
            las[t]  = {$random(seed), $random(seed), $random(seed), $random(seed)};
        end
        @(posedge clk);
        team_pad <= pads;
        team_la  <= las;
    endtask

    task automatic test_reset_state();
        logic [DATA_W-1:0] d;
        check_pad(pins_now(), IDLE_PINS, "GPIO pins after reset");
        check_la(la_out, '0, "LA outputs after reset");
        wb_read(HOST, GPIO_ADR, d);
        check_data(d, 32'd3, "gpio_sel after reset");   // No team selected
        wb_read(HOST, LA_ADR, d);
        check_data(d, 32'd3, "la_sel after reset");
        wb_read(HOST, {REGION_PAD, 24'h8}, d);
        check_data(d, '0, "unused pad offset");
    endtask

    task automatic test_sram();
        logic [DATA_W-1:0] d;
        logic [DATA_W-1:0] exp;
        logic [DATA_W-1:0] wdata;
        logic [7:0]        w;
        logic [SEL_W-1:0]  lanes;
        for (int i = 0; i < 4; i++) begin
            w   = 8'(37 * i + 5);
            exp = {w, ~w, w ^ 8'h5a, 8'hc3};
            wb_write(HOST, sram_adr(w), exp, '1);
            wb_read(HOST, sram_adr(w), d);
            check_data(d, exp, "SRAM full word");
            lanes = SEL_W'(5 * i + 1);   // 0001, 0110, 1011 and none
            wdata = {8'ha0, 8'hb1, 8'hc2, 8'hd3} ^ {4{w}};
            wb_write(HOST, sram_adr(w), wdata, lanes);
            exp = merge_bytes(exp, wdata, lanes);
            wb_read(HOST, sram_adr(w), d);
            check_data(d, exp, "SRAM partial write");
        end
    endtask

    task automatic test_pad_select();
        logic [DATA_W-1:0] d;
        for (int t = 0; t < NUM_TEAMS; t++) begin
            wb_write(HOST, GPIO_ADR, DATA_W'(t), '1);
            wb_write(HOST, LA_ADR, DATA_W'(t), '1);
            wb_read(HOST, GPIO_ADR, d);
            check_data(d, DATA_W'(t), "gpio_sel");
            wb_read(HOST, LA_ADR, d);
            check_data(d, DATA_W'(t), "la_sel");
            check_pad(pins_now(), team_pad[t], "GPIO pins");
            check_la(la_out, team_la[t], "LA outputs");
        end
        wb_write(HOST, GPIO_ADR, 32'd3, '1);
        wb_write(HOST, LA_ADR, 32'd3, '1);
        check_pad(pins_now(), IDLE_PINS, "idle GPIO pins");
        check_la(la_out, '0, "idle LA outputs");
    endtask

    task automatic test_team_access();
        logic [DATA_W-1:0] d;
        logic [DATA_W-1:0] exp;
        logic [7:0]        w;
        for (int t = 0; t < NUM_TEAMS; t++) begin
            w   = 8'(128 + t);   // Own word per team
            exp = {8'hbe, 8'(t), w, 8'hef};
            wb_write(team_mgr(t), sram_adr(w), exp, '1);
            wb_read(team_mgr(t), sram_adr(w), d);
            check_data(d, exp, "team SRAM word");
        end
        wb_write(HOST, NONE_ADR, 32'hdead_beef, '1);
        wb_read(HOST, NONE_ADR, d);
        check_data(d, '0, "unmapped read by host");
        wb_read(team_mgr(2), NONE_ADR, d);
        check_data(d, '0, "unmapped read by team 2");
    endtask

    task automatic test_contention();
        logic [DATA_W-1:0] d;
        apply_reset();   // Host searched first again
        fork
            wb_write(HOST, sram_adr(8'h42), 32'h1111_1111, '1);
            wb_write(team_mgr(0), sram_adr(8'h42), 32'h2222_2222, '1);
        join
        wb_read(HOST, sram_adr(8'h42), d);
        check_data(d, 32'h2222_2222, "contended word");   // Team 0 served second
    endtask

    initial begin
        reset    <= 1'b1;
        mgr_req  <= '0;
        team_pad <= '0;
        team_la  <= '0;
        seed     = 32'hd54b_2311;
        load_team_inputs();
        apply_reset();
        test_reset_state();
        test_sram();
        test_pad_select();
        test_team_access();
        test_contention();
        $display("Test OK");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: bus traffic did not finish within %0d clock cycles",
                 WATCHDOG_CYCLES);
        stop_on_error();
    end

endmodule
